// File: bench/perint_stim.txt
// columns: op (1 write, 2 read, 3 swap), word address, write data, byte select, expected rdata
// all hex; writes expect zero data, slots sit at 10, 20, 30 and the device table at 00
2 00000010 00000000 0 00000000
2 0000001f 00000000 0 00000000
2 00000020 00000000 0 00000000
2 0000002f 00000000 0 00000000
2 00000030 00000000 0 00000000
2 0000003f 00000000 0 00000000
1 00000010 11223344 f 00000000
1 00000020 aabbccdd f 00000000
1 00000030 55667788 f 00000000
1 00000011 deadbeef 5 00000000
1 00000021 cafef00d a 00000000
1 00000010 99999999 2 00000000
1 0000003f 01020304 c 00000000
2 00000010 00000000 0 11229944
2 00000011 00000000 0 00ad00ef
2 00000020 00000000 0 aabbccdd
2 00000021 00000000 0 ca00f000
2 00000030 00000000 0 55667788
2 0000003f 00000000 0 01020000
2 00000031 00000000 0 00000000
3 00000020 12345678 f aabbccdd
2 00000020 00000000 0 12345678
3 00000011 ffffffff 9 00ad00ef
2 00000011 00000000 0 ffad00ff
3 0000003f 00000000 0 01020000
2 0000003f 00000000 0 01020000
2 00000000 00000000 0 00000007
2 00000001 00000000 0 00000001
2 00000002 00000000 0 00000001
2 00000003 00000000 0 00000001
2 00000008 00000000 0 00000010
2 0000000b 00000000 0 00000010
2 00000004 00000000 0 00000000
1 00000000 ffffffff f 00000000
3 00000009 12345678 f 00000010
2 00000000 00000000 0 00000007
2 00000009 00000000 0 00000010
2 00000040 00000000 0 00000000
1 00000040 ffffffff f 00000000
3 00000041 12345678 f 00000000
2 3fffffff 00000000 0 00000000
1 00000050 ffffffff f 00000000
2 00000010 00000000 0 11229944

// File: filelist.f
src/perint_pkg.sv
src/perint_decoder.sv
src/mem_slot.sv
src/dev_table.sv
src/perint_response_mux.sv
src/perint_top.sv
bench/tb_perint_top.sv

// File: Bender.yml
package:
  name: perint

sources:
  - src/perint_pkg.sv
  - src/perint_decoder.sv
  - src/mem_slot.sv
  - src/dev_table.sv
  - src/perint_response_mux.sv
  - src/perint_top.sv
  - target: test
    files:
      - bench/tb_perint_top.sv

// File: bench/tb_perint_top.sv
`timescale 1ns/1ps
// runs bench/perint_stim.txt from the project root, one request in flight at a time
// every request must return rdy_o exactly three cycles after the DUT samples it
module tb_perint_top;

	localparam int max_reqs = 64;
	localparam int reset_cycles = 3;
	localparam int latency = 3;
	localparam int poll_limit = 10;
	localparam int cycles_per_req = 20;

	logic                             clk100mhz;
	logic                             rst_p;
	perint_pkg::op_t                  op_i;
	logic [perint_pkg::addr_bits-1:0] addr_i;
	logic [perint_pkg::arch_bits-1:0] wdata_i;
	logic [perint_pkg::sel_bits-1:0]  sel_i;
	logic [perint_pkg::arch_bits-1:0] rdata_o;
	logic                             rdy_o;

	logic [31:0] req_op [max_reqs];
	logic [31:0] req_addr [max_reqs];
	logic [31:0] req_wdata [max_reqs];
	logic [31:0] req_sel [max_reqs];
	logic [31:0] req_exp [max_reqs];
	int          req_count;
	int          data_errors;
	int          timing_errors;
	bit          loaded;

	perint_top perint_top_i (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.sel_i     (sel_i),
		.rdata_o   (rdata_o),
		.rdy_o     (rdy_o)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	// comment and blank lines do not scan as five hex fields and are skipped
	task automatic load_requests();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_op, f_addr, f_wdata, f_sel, f_exp;
		req_count = 0;
		fd = $fopen("bench/perint_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/perint_stim.txt");
		end else begin
			while (!$feof(fd) && (req_count < max_reqs)) begin
				n = $fgets(line, fd);
				if ((n > 0) && ($sscanf(line, "%h %h %h %h %h",
						f_op, f_addr, f_wdata, f_sel, f_exp) == 5)) begin
					req_op[req_count] = f_op;
					req_addr[req_count] = f_addr;
					req_wdata[req_count] = f_wdata;
					req_sel[req_count] = f_sel;
					req_exp[req_count] = f_exp;
					req_count++;
				end
			end
			$fclose(fd);
		end
	endtask

	function automatic string request_name(input int idx);
		string op_name;
		case (req_op[idx][1:0])
			2'd1: op_name = "WRITE";
			2'd2: op_name = "READ";
			2'd3: op_name = "SWAP";
			default: op_name = "NOP";
		endcase
		return $sformatf("req %0d %s @%h", idx, op_name, req_addr[idx]);
	endfunction

	// called on a rising edge, returns on the edge where rdy_o is seen high
	task automatic run_request(input int idx, output bit stuck);
		int cycles;
		stuck = 1'b0;
		op_i <= perint_pkg::op_t'(req_op[idx][1:0]);
		addr_i <= req_addr[idx][perint_pkg::addr_bits-1:0];
		wdata_i <= req_wdata[idx];
		sel_i <= req_sel[idx][perint_pkg::sel_bits-1:0];
		// the DUT samples the request here, the last rdy pulse must be over
		@(posedge clk100mhz);
		if (rdy_o) begin
			timing_errors++;
			$display("rdy_o was high for more than one cycle before %s", request_name(idx));
		end
		cycles = 0;
		do begin
			@(posedge clk100mhz);
			cycles++;
		end while (!rdy_o && (cycles < poll_limit));
		if (!rdy_o) begin
			stuck = 1'b1;
			timing_errors++;
			$display("%s got no rdy_o within %0d cycles", request_name(idx), poll_limit);
		end else begin
			if (cycles != latency) begin
				timing_errors++;
				$display("[ERROR] %s latency: expected %0d actual %0d",
					request_name(idx), latency, cycles);
			end
			if (rdata_o !== req_exp[idx]) begin
				data_errors++;
				$display("[ERROR] %s rdata: expected %h actual %h",
					request_name(idx), req_exp[idx], rdata_o);
			end
		end
	endtask

	initial begin
		bit stuck;
		int done_count;
		rst_p = 1'b1;
		op_i = perint_pkg::OP_NOP;
		addr_i = '0;
		wdata_i = '0;
		sel_i = '0;
		data_errors = 0;
		timing_errors = 0;
		stuck = 1'b0;
		done_count = 0;
		load_requests();
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk100mhz);
		rst_p <= 1'b0;
		@(posedge clk100mhz);
		if (req_count == 0) begin
			data_errors++;
			$display("no requests were read from the stimulus file");
		end
		for (int i = 0; (i < req_count) && !stuck; i++) begin
			run_request(i, stuck);
			done_count++;
		end
		if (!stuck) begin
			op_i <= perint_pkg::OP_NOP;
			@(posedge clk100mhz);
			if (rdy_o) begin
				timing_errors++;
				$display("rdy_o was high for more than one cycle after the last request");
			end
		end
		$display("summary: %0d of %0d requests run, %0d data errors, %0d timing errors",
			done_count, req_count, data_errors, timing_errors);
		if ((data_errors == 0) && (timing_errors == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// budget grows with the number of requests in the file
	initial begin
		wait (loaded);
		repeat (req_count * cycles_per_req + reset_cycles + 2) @(posedge clk100mhz);
		$display("watchdog expired before all requests completed");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: src/perint_top.sv
`timescale 1ns/1ps
// single-master PerInt interconnect, fixed three-cycle latency from request to rdy
// one outstanding request; the master holds op and fields until rdy
module perint_top (
	input  logic                             clk100mhz,
	input  logic                             rst_p,
	input  perint_pkg::op_t                  op_i,
	input  logic [perint_pkg::addr_bits-1:0] addr_i,
	input  logic [perint_pkg::arch_bits-1:0] wdata_i,
	input  logic [perint_pkg::sel_bits-1:0]  sel_i,
	output logic [perint_pkg::arch_bits-1:0] rdata_o,
	output logic                             rdy_o
);

	perint_pkg::op_t                       slv_op [perint_pkg::slave_count];
	logic [perint_pkg::map_base_bits-1:0]  slv_offset;
	logic [perint_pkg::arch_bits-1:0]      slv_wdata;
	logic [perint_pkg::sel_bits-1:0]       slv_sel;
	logic [perint_pkg::slave_idx_bits-1:0] sel_idx;
	logic                                  def_stb;
	wire  [perint_pkg::arch_bits-1:0]      slv_rdata [perint_pkg::slave_count];
	wire  [perint_pkg::slave_count-1:0]    slv_rdy;

	perint_decoder perint_decoder_i (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.sel_i        (sel_i),
		.done_i       (rdy_o),
		.slv_op_o     (slv_op),
		.slv_offset_o (slv_offset),
		.slv_wdata_o  (slv_wdata),
		.slv_sel_o    (slv_sel),
		.sel_idx_o    (sel_idx),
		.def_stb_o    (def_stb)
	);

	dev_table dev_table_i (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.slv_op_i     (slv_op[perint_pkg::slave_devtbl]),
		.slv_offset_i (slv_offset),
		.slv_rdata_o  (slv_rdata[perint_pkg::slave_devtbl]),
		.slv_rdy_o    (slv_rdy[perint_pkg::slave_devtbl])
	);

	// slots follow the device table in the slave numbering
	for (genvar i = 0; i < perint_pkg::slot_count; i++) begin : gen_slot
		mem_slot mem_slot_i (
			.clk100mhz    (clk100mhz),
			.rst_p        (rst_p),
			.slv_op_i     (slv_op[perint_pkg::slave_slot_base + i]),
			.slv_offset_i (slv_offset),
			.slv_wdata_i  (slv_wdata),
			.slv_sel_i    (slv_sel),
			.slv_rdata_o  (slv_rdata[perint_pkg::slave_slot_base + i]),
			.slv_rdy_o    (slv_rdy[perint_pkg::slave_slot_base + i])
		);
	end

	perint_response_mux perint_response_mux_i (
		.clk100mhz   (clk100mhz),
		.rst_p       (rst_p),
		.slv_rdata_i (slv_rdata),
		.slv_rdy_i   (slv_rdy),
		.sel_idx_i   (sel_idx),
		.def_stb_i   (def_stb),
		.rdata_o     (rdata_o),
		.rdy_o       (rdy_o)
	);

endmodule

// File: src/perint_response_mux.sv
`timescale 1ns/1ps
// one register stage between the slave answers and the master
// the default slave has no logic of its own, it is a delayed strobe with zero data
module perint_response_mux (
	input  logic                                  clk100mhz,
	input  logic                                  rst_p,
	input  logic [perint_pkg::arch_bits-1:0]      slv_rdata_i [perint_pkg::slave_count],
	input  logic [perint_pkg::slave_count-1:0]    slv_rdy_i,
	input  logic [perint_pkg::slave_idx_bits-1:0] sel_idx_i,
	input  logic                                  def_stb_i,
	output logic [perint_pkg::arch_bits-1:0]      rdata_o,
	output logic                                  rdy_o
);

	logic                             def_stb_q;
	logic [perint_pkg::arch_bits-1:0] pick_data;
	logic                             pick_rdy;

	// matches the one-cycle answer of the real slaves
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			def_stb_q <= 1'b0;
		end else begin
			def_stb_q <= def_stb_i;
		end
	end

	always_comb begin
		pick_data = '0;
		pick_rdy = (sel_idx_i == perint_pkg::slave_default) ? def_stb_q : 1'b0;
		for (int i = 0; i < perint_pkg::slave_count; i++) begin
			if (sel_idx_i == perint_pkg::slave_idx_bits'(i)) begin
				pick_data = slv_rdata_i[i];
				pick_rdy = slv_rdy_i[i];
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rdy_o <= 1'b0;
		end else begin
			rdy_o <= pick_rdy;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (pick_rdy) begin
			rdata_o <= pick_data;
		end
	end

	// only one transfer in flight, so at most one answer per cycle
	one_answer_a: assert property (@(posedge clk100mhz) disable iff (rst_p)
		$onehot0({def_stb_q, slv_rdy_i}));

endmodule

// File: src/dev_table.sv
`timescale 1ns/1ps
// read-only table: ids at offsets 0..3, window size at 8..11, zero elsewhere
// writes are dropped but still answered, with zero data
module dev_table (
	input  logic                                 clk100mhz,
	input  logic                                 rst_p,
	input  perint_pkg::op_t                      slv_op_i,
	input  logic [perint_pkg::map_base_bits-1:0] slv_offset_i,
	output logic [perint_pkg::arch_bits-1:0]     slv_rdata_o,
	output logic                                 slv_rdy_o
);

	logic [perint_pkg::arch_bits-1:0] lookup;
	logic                             rd_en;

	assign rd_en = (slv_op_i == perint_pkg::OP_READ) || (slv_op_i == perint_pkg::OP_SWAP);

	// upper two offset bits pick the field, lower two the slave
	always_comb begin
		case (slv_offset_i[perint_pkg::map_base_bits-1 -: 2])
			2'b00: lookup = perint_pkg::dev_id_table[slv_offset_i[1:0]];
			2'b10: lookup = perint_pkg::arch_bits'(perint_pkg::map_words);
			default: lookup = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			slv_rdy_o <= 1'b0;
		end else begin
			slv_rdy_o <= (slv_op_i != perint_pkg::OP_NOP);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (slv_op_i != perint_pkg::OP_NOP) begin
			slv_rdata_o <= rd_en ? lookup : '0;
		end
	end

endmodule

// File: src/mem_slot.sv
`timescale 1ns/1ps
// sixteen-word memory slave, cleared by reset; writes are byte-qualified
// WRITE answers with zero data, READ and SWAP with the word held before the edge
module mem_slot (
	input  logic                                 clk100mhz,
	input  logic                                 rst_p,
	input  perint_pkg::op_t                      slv_op_i,
	input  logic [perint_pkg::map_base_bits-1:0] slv_offset_i,
	input  logic [perint_pkg::arch_bits-1:0]     slv_wdata_i,
	input  logic [perint_pkg::sel_bits-1:0]      slv_sel_i,
	output logic [perint_pkg::arch_bits-1:0]     slv_rdata_o,
	output logic                                 slv_rdy_o
);

	logic [perint_pkg::arch_bits-1:0] mem_q [perint_pkg::map_words];
	logic                             wr_en;
	logic                             rd_en;

	assign wr_en = (slv_op_i == perint_pkg::OP_WRITE) || (slv_op_i == perint_pkg::OP_SWAP);
	assign rd_en = (slv_op_i == perint_pkg::OP_READ) || (slv_op_i == perint_pkg::OP_SWAP);

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			for (int i = 0; i < perint_pkg::map_words; i++) begin
				mem_q[i] <= '0;
			end
			slv_rdy_o <= 1'b0;
		end else begin
			slv_rdy_o <= (slv_op_i != perint_pkg::OP_NOP);
			if (wr_en) begin
				// untouched bytes keep their old value
				for (int b = 0; b < perint_pkg::sel_bits; b++) begin
					if (slv_sel_i[b]) begin
						mem_q[slv_offset_i][8*b +: 8] <= slv_wdata_i[8*b +: 8];
					end
				end
			end
		end
	end

	// swap returns the old word since the write lands on the same edge
	always_ff @(posedge clk100mhz) begin
		if (slv_op_i != perint_pkg::OP_NOP) begin
			slv_rdata_o <= rd_en ? mem_q[slv_offset_i] : '0;
		end
	end

	// the decoder never strobes a slave on back-to-back cycles
	rdy_single_a: assert property (@(posedge clk100mhz) disable iff (rst_p)
		slv_rdy_o |=> !slv_rdy_o);

endmodule

// File: src/perint_decoder.sv
`timescale 1ns/1ps
// accepts one request at a time; the master waits until rdy comes back
// the slave strobe is issued one cycle after the request is sampled
module perint_decoder (
	input  logic                                  clk100mhz,
	input  logic                                  rst_p,
	input  perint_pkg::op_t                       op_i,
	input  logic [perint_pkg::addr_bits-1:0]      addr_i,
	input  logic [perint_pkg::arch_bits-1:0]      wdata_i,
	input  logic [perint_pkg::sel_bits-1:0]       sel_i,
	input  logic                                  done_i,
	output perint_pkg::op_t                       slv_op_o [perint_pkg::slave_count],
	output logic [perint_pkg::map_base_bits-1:0]  slv_offset_o,
	output logic [perint_pkg::arch_bits-1:0]      slv_wdata_o,
	output logic [perint_pkg::sel_bits-1:0]       slv_sel_o,
	output logic [perint_pkg::slave_idx_bits-1:0] sel_idx_o,
	output logic                                  def_stb_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,
		ST_WAIT
	} state_t;

	state_t                                state_q;
	perint_pkg::op_t                       req_op_q;
	logic [perint_pkg::slave_idx_bits-1:0] req_idx_q;
	logic [perint_pkg::slave_idx_bits-1:0] dec_idx;
	logic                                  accept;

	assign accept = (state_q == ST_IDLE) && (op_i != perint_pkg::OP_NOP);

	// window number is the address divided by map_words
	always_comb begin
		if (addr_i >= perint_pkg::addr_bits'(perint_pkg::map_end)) begin
			dec_idx = perint_pkg::slave_default;
		end else begin
			dec_idx = perint_pkg::slave_idx_bits'(addr_i >> perint_pkg::map_base_bits);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			state_q <= ST_IDLE;
			req_op_q <= perint_pkg::OP_NOP;
			req_idx_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= ST_STROBE;
						req_op_q <= op_i;
						req_idx_q <= dec_idx;
					end
				end
				ST_STROBE: state_q <= ST_WAIT;
				// rdy back at the master closes the transfer
				ST_WAIT: begin
					if (done_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept) begin
			slv_offset_o <= addr_i[perint_pkg::map_base_bits-1:0];
			slv_wdata_o <= wdata_i;
			slv_sel_o <= sel_i;
		end
	end

	// only the selected slave sees the op, and only for one cycle
	always_comb begin
		for (int i = 0; i < perint_pkg::slave_count; i++) begin
			if ((state_q == ST_STROBE) && (req_idx_q == perint_pkg::slave_idx_bits'(i))) begin
				slv_op_o[i] = req_op_q;
			end else begin
				slv_op_o[i] = perint_pkg::OP_NOP;
			end
		end
	end

	assign def_stb_o = (state_q == ST_STROBE) && (req_idx_q == perint_pkg::slave_default);
	assign sel_idx_o = req_idx_q;

	// the master keeps its op until it sees rdy
	op_held_a: assert property (@(posedge clk100mhz) disable iff (rst_p)
		((state_q != ST_IDLE) && !done_i) |-> (op_i == req_op_q));

endmodule

// File: src/perint_pkg.sv
// widths, op encoding and the fixed map of one device table plus three memory slots
// each slave owns a map_words window; word addresses from map_end up reach the default slave
package perint_pkg;

	// data path
	localparam int arch_bits = 32;
	localparam int addr_bits = 30;
	localparam int sel_bits = arch_bits / 8;

	// bus ops, same two-bit encoding as the PerInt op lines
	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_SWAP  = 2'd3
	} op_t;

	// slave numbering
	localparam int slot_count = 3;
	localparam int slave_count = slot_count + 1;
	localparam int slave_idx_bits = 3;
	localparam int slave_devtbl = 0;
	localparam int slave_slot_base = 1;
	// one past the real slaves, still fits in slave_idx_bits
	localparam logic [slave_idx_bits-1:0] slave_default = 3'd4;

	// address map
	localparam int map_words = 16;
	localparam int map_base_bits = 4;
	localparam int map_end = slave_count * map_words;

	// device ids, entry 0 is the device table itself and 1..3 are the memory slots
	localparam logic [slave_count-1:0][arch_bits-1:0] dev_id_table = {
		32'd1,
		32'd1,
		32'd1,
		32'd7
	};

endpackage
